// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - src
    files:
      - src/id_pkg.sv
      - src/regfile.sv
      - src/decoder.sv
      - src/pipe_reg.sv
      - src/id_stage.sv
      - src/decode_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/decode_chk.sv
      - verification/decode_tb.sv

// ==== sim.f ====
+incdir+src
src/id_pkg.sv
src/regfile.sv
src/decoder.sv
src/pipe_reg.sv
src/id_stage.sv
src/decode_top.sv
verification/decode_chk.sv
verification/decode_tb.sv

// ==== verification/decode_tb.sv ====
// clock, reset, LFSR stimulus, per-test reports and final verdict for the decode stage
`include "id_macros.svh"

module decode_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic            clock = 1'b0;
  logic            rst;
  logic            stall;
  logic            flush;
  id_pkg::if_id_t  if_id_in;
  id_pkg::wb_reg_t wb_in;
  id_pkg::id_ex_t  id_ex_out;

  logic [31:0] lfsr_state = 32'h5628e231;
  int          tests_run = 0;
  int          tests_failed = 0;
  int unsigned errs_at_start = 0;  // checker count when the test began

  logic [6:0] legal_fn [8] = '{`ID_FN_ADD, `ID_FN_SUB, `ID_FN_AND, `ID_FN_BIS,
                               `ID_FN_XOR, `ID_FN_SLL, `ID_FN_SRL, `ID_FN_CMPEQ};
  logic [5:0] mem_br_ops [6] = '{`ID_OP_LDQ, `ID_OP_STQ, `ID_OP_LDQ_L,
                                 `ID_OP_STQ_C, `ID_OP_BR, `ID_OP_BCOND};

  decode_top DUT (.*);

  always #5 clock = ~clock;  // 10 ns period

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // taps 32 22 2 1
  endfunction

  // n random bits with one LFSR step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic id_pkg::wb_reg_t random_wb();
    id_pkg::wb_reg_t wb;
    wb.wr_en   = 1'(rand_bits(1));
    wb.wr_idx  = 5'(rand_bits(5));
    wb.wr_data = rand_bits(64);
    return wb;
  endfunction

  // operate word in register or 8-bit literal form
  function automatic logic [31:0] op_word(input logic [6:0] fn, input logic lit);
    if (lit)
      return {`ID_OP_INTOP, 5'(rand_bits(5)), 8'(rand_bits(8)), 1'b1, fn, 5'(rand_bits(5))};
    else
      return {`ID_OP_INTOP, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'b000, 1'b0, fn,
              5'(rand_bits(5))};
  endfunction

  function automatic logic [31:0] add_word(input logic [4:0] ra, input logic [4:0] rb);
    return {`ID_OP_INTOP, ra, rb, 3'b000, 1'b0, `ID_FN_ADD, 5'd1};
  endfunction

  // one cycle of inputs applied on the falling edge
  task automatic drive_cycle(input logic vld, input logic [31:0] word,
                             input id_pkg::wb_reg_t wb);
    @(negedge clock);
    if_id_in.valid = vld;
    if_id_in.npc   = rand_bits(64);
    if_id_in.inst  = word;
    wb_in          = wb;
  endtask

  // an illegal word leaves valid low but still occupies the slot
  function automatic logic pipe_busy();
    return DUT.if_id_q.valid !== 1'b0 || id_ex_out.valid !== 1'b0 ||
           id_ex_out.illegal !== 1'b0;
  endfunction

  // bubbles until both registers are empty
  task automatic drain(input string test);
    int n;
    n = 0;
    do begin
      drive_cycle(1'b0, 32'h0, '0);
      n++;
    end while (pipe_busy() && n < 8);
    if (pipe_busy()) begin
      $display("timeout: pipeline still busy after %0d bubbles in test %s", n, test);
      $display("Simulation failed");
      $finish;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (DUT.chk.err_count != errs_at_start) begin
      tests_failed++;
      $display("FAILED %s: %s got %h expected %h", name, DUT.chk.err_sig,
               DUT.chk.err_got, DUT.chk.err_exp);
    end else begin
      $display("%s: pass", name);
    end
    errs_at_start = DUT.chk.err_count;
  endtask

  //////////////////////////////////////////////////////////////////////
  initial begin
    rst      = 1'b1;
    stall    = 1'b0;
    flush    = 1'b0;
    if_id_in = '0;
    wb_in    = '0;

    repeat (4) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    drain("reset");
    end_test("reset");

    // every register including r31 gets a value before any read counts
    for (int i = 0; i < `ID_NREGS; i++) begin
      drive_cycle(1'b0, 32'h0, '{wr_en: 1'b1, wr_idx: 5'(i), wr_data: rand_bits(64)});
    end

    for (int i = 0; i < 40; i++) begin
      drive_cycle(1'b1, op_word(legal_fn[3'(rand_bits(3))], 1'(rand_bits(1))), random_wb());
    end
    drain("operate");
    end_test("operate");

    for (int i = 0; i < 24; i++) begin
      drive_cycle(1'b1, {mem_br_ops[i % 6], 26'(rand_bits(26))}, random_wb());
    end
    drive_cycle(1'b1, {`ID_OP_PAL, `ID_PAL_HALT}, '0);
    drive_cycle(1'b1, {`ID_OP_PAL, `ID_PAL_CPUID}, '0);
    drain("memory_branch");
    end_test("memory_branch");

    drive_cycle(1'b0, 32'h0, '{1'b1, 5'd31, rand_bits(64)});  // dropped write
    drive_cycle(1'b1, add_word(5'd31, 5'd31), '0);
    drive_cycle(1'b1, add_word(5'd7, 5'd9), '0);
    drive_cycle(1'b0, 32'h0, '{1'b1, 5'd7, rand_bits(64)});   // forwarded to ra
    drive_cycle(1'b1, add_word(5'd3, 5'd14), '0);
    drive_cycle(1'b0, 32'h0, '{1'b1, 5'd14, rand_bits(64)});  // forwarded to rb
    drive_cycle(1'b1, add_word(5'd31, 5'd12), '0);
    drive_cycle(1'b0, 32'h0, '{1'b1, 5'd31, rand_bits(64)});  // r31 still zero
    for (int i = 0; i < 24; i++) begin
      drive_cycle(1'b1, op_word(legal_fn[3'(rand_bits(3))], 1'b0), random_wb());
    end
    drain("registers");
    end_test("registers");

    drive_cycle(1'b1, {6'h01, 26'(rand_bits(26))}, '0);  // unknown opcodes
    drive_cycle(1'b1, {6'h1a, 26'(rand_bits(26))}, '0);
    drive_cycle(1'b1, {6'h3f, 26'(rand_bits(26))}, '0);
    drive_cycle(1'b1, {`ID_OP_INTOP, 5'd1, 5'd2, 3'b000, 1'b0, 7'h7f, 5'd3}, '0);
    drive_cycle(1'b1, {`ID_OP_INTOP, 5'd4, 8'h5a, 1'b1, 7'h01, 5'd6}, '0);
    drive_cycle(1'b1, {`ID_OP_PAL, 26'h0001234}, '0);
    drain("illegal");
    end_test("illegal");

    for (int i = 0; i < 3; i++) begin
      drive_cycle(1'b1, op_word(legal_fn[3'(rand_bits(3))], 1'(rand_bits(1))), random_wb());
    end
    stall = 1'b1;  // holds for the next three edges
    for (int i = 0; i < 3; i++) begin
      drive_cycle(1'b1, op_word(legal_fn[3'(rand_bits(3))], 1'(rand_bits(1))), random_wb());
    end
    stall = 1'b0;
    drive_cycle(1'b1, op_word(`ID_FN_XOR, 1'b1), random_wb());
    drive_cycle(1'b1, op_word(`ID_FN_SUB, 1'b0), random_wb());
    stall = 1'b1;
    flush = 1'b1;  // flush has priority
    drive_cycle(1'b0, 32'h0, '0);
    stall = 1'b0;
    flush = 1'b0;
    drain("stall_flush");
    end_test("stall_flush");

    $display("tests run %0d, tests failed %0d, assertion errors %0d",
             tests_run, tests_failed, DUT.chk.err_count);
    if (tests_failed == 0 && DUT.chk.err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verification/decode_chk.sv ====
// shadow register file, two-deep pipeline model and ID/EX packet assertions, bound to the top
`include "id_macros.svh"

module decode_chk (
  input logic            clock,
  input logic            rst,
  input logic            stall,
  input logic            flush,
  input id_pkg::if_id_t  if_id_in,
  input id_pkg::wb_reg_t wb_in,
  input id_pkg::id_ex_t  id_ex_out
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned         err_count = 0;  // failures so far
  string               err_sig = "none";
  logic [63:0]         err_got = '0;
  logic [63:0]         err_exp = '0;

  logic [`ID_XLEN-1:0] shadow [`ID_NREGS];  // architectural register model
  id_pkg::if_id_t      fetch_q;             // mirrors IF/ID
  id_pkg::if_id_t      fetch_qq;            // mirrors the slot now in ID/EX
  logic [`ID_XLEN-1:0] rega_qq;
  logic [`ID_XLEN-1:0] regb_qq;
  id_pkg::id_ex_t      out_q;               // id_ex_out one edge back

  logic [7:0]          exp_fl;  // rd wr ldl stc cond uncond halt cpuid
  logic                exp_ill;
  logic                fn_bad;
  logic [4:0]          exp_dest;
  id_pkg::alu_func_e   exp_alu;
  id_pkg::opa_sel_e    exp_opa;
  id_pkg::opb_sel_e    exp_opb;
  logic [9:0]          exp_flags;  // exp_fl, illegal, valid
  logic [9:0]          got_flags;
  logic                exp_is_op;

  // ISA register read with r31 as zero and a same-cycle write forwarded
  function automatic logic [`ID_XLEN-1:0] model_read(input logic [4:0] idx);
    if (idx == `ID_ZERO_REG)
      return '0;
    if (wb_in.wr_en && (wb_in.wr_idx == idx))
      return wb_in.wr_data;
    return shadow[idx];
  endfunction

  function automatic void log_failure(input string sig, input logic [63:0] got,
                                      input logic [63:0] exp_v);
    err_count++;
    err_sig = sig;
    err_got = got;
    err_exp = exp_v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  always_ff @(posedge clock) begin
    if (wb_in.wr_en && (wb_in.wr_idx != `ID_ZERO_REG)) begin
      shadow[wb_in.wr_idx] <= wb_in.wr_data;  // commits under stall too
    end
  end

  always_ff @(posedge clock) begin
    out_q <= id_ex_out;
    if (rst || flush) begin
      fetch_q  <= '0;
      fetch_qq <= '0;
      rega_qq  <= '0;
      regb_qq  <= '0;
    end else if (!stall) begin
      fetch_q  <= if_id_in;
      fetch_qq <= fetch_q;
      rega_qq  <= model_read(fetch_q.inst[25:21]);  // ra field
      regb_qq  <= model_read(fetch_q.inst[20:16]);  // rb field
    end
  end

  always_comb begin
    exp_fl  = '0;
    exp_ill = 1'b0;
    fn_bad  = 1'b0;
    exp_alu = id_pkg::ALU_ADDQ;
    exp_opa = id_pkg::OPA_REGA;
    exp_opb = id_pkg::OPB_REGB;
    case (fetch_qq.inst[11:5])
      `ID_FN_ADD:   exp_alu = id_pkg::ALU_ADDQ;
      `ID_FN_SUB:   exp_alu = id_pkg::ALU_SUBQ;
      `ID_FN_AND:   exp_alu = id_pkg::ALU_AND;
      `ID_FN_BIS:   exp_alu = id_pkg::ALU_BIS;
      `ID_FN_XOR:   exp_alu = id_pkg::ALU_XOR;
      `ID_FN_SLL:   exp_alu = id_pkg::ALU_SLL;
      `ID_FN_SRL:   exp_alu = id_pkg::ALU_SRL;
      `ID_FN_CMPEQ: exp_alu = id_pkg::ALU_CMPEQ;
      default:      fn_bad  = 1'b1;
    endcase
    case (fetch_qq.inst[31:26])
      `ID_OP_INTOP: begin
        exp_ill = fn_bad;
        exp_opb = fetch_qq.inst[12] ? id_pkg::OPB_LIT : id_pkg::OPB_REGB;  // literal bit
      end
      `ID_OP_LDQ:   exp_fl  = 8'b1000_0000;
      `ID_OP_STQ:   exp_fl  = 8'b0100_0000;
      `ID_OP_LDQ_L: exp_fl  = 8'b1010_0000;  // load plus lock
      `ID_OP_STQ_C: exp_fl  = 8'b0101_0000;
      `ID_OP_BR:    exp_fl  = 8'b0000_0100;
      `ID_OP_BCOND: exp_fl  = 8'b0000_1000;
      `ID_OP_PAL: begin
        exp_fl[1] = (fetch_qq.inst[25:0] == `ID_PAL_HALT);
        exp_fl[0] = (fetch_qq.inst[25:0] == `ID_PAL_CPUID);
        exp_ill   = ~|exp_fl;  // any other PAL code
      end
      default: exp_ill = 1'b1;
    endcase
    // memory ops add a displacement to rb, branches to npc
    case (fetch_qq.inst[31:26])
      `ID_OP_LDQ, `ID_OP_STQ, `ID_OP_LDQ_L, `ID_OP_STQ_C: begin
        exp_opa = id_pkg::OPA_REGB;
        exp_opb = id_pkg::OPB_MEM_DISP;
      end
      `ID_OP_BR, `ID_OP_BCOND: begin
        exp_opa = id_pkg::OPA_NPC;
        exp_opb = id_pkg::OPB_BR_DISP;
      end
      default: ;
    endcase
    case (fetch_qq.inst[31:26])
      `ID_OP_INTOP:                                      exp_dest = fetch_qq.inst[4:0];
      `ID_OP_LDQ, `ID_OP_LDQ_L, `ID_OP_STQ_C, `ID_OP_BR: exp_dest = fetch_qq.inst[25:21];
      default:                                           exp_dest = `ID_ZERO_REG;
    endcase
    if (!fetch_qq.valid) begin  // bubble decodes as nothing
      exp_fl  = '0;
      exp_ill = 1'b0;
    end
    exp_flags = {exp_fl, exp_ill, fetch_qq.valid & ~exp_ill};
    exp_is_op = exp_flags[0] && (fetch_qq.inst[31:26] == `ID_OP_INTOP);
  end

  assign got_flags = {id_ex_out.rd_mem, id_ex_out.wr_mem, id_ex_out.ldl_mem, id_ex_out.stc_mem,
                      id_ex_out.cond_branch, id_ex_out.uncond_branch, id_ex_out.halt,
                      id_ex_out.cpuid, id_ex_out.illegal, id_ex_out.valid};

  //////////////////////////////////////////////////////////////////////
  // checks on the ID/EX output
  a_reset: assert property (@(posedge clock) rst |=> got_flags == '0)
    else begin
      log_failure("id_ex_out flags after reset", 64'($sampled(got_flags)), '0);
      $error("control flags active after reset");
    end

  a_flags: assert property (@(posedge clock) disable iff (rst) got_flags == exp_flags)
    else begin
      log_failure("id_ex_out flags", 64'($sampled(got_flags)), 64'($sampled(exp_flags)));
      $error("control flags differ from decode rules");
    end

  a_dest: assert property (@(posedge clock) disable iff (rst)
                           exp_flags[0] |-> id_ex_out.dest_reg_idx == exp_dest)
    else begin
      log_failure("id_ex_out.dest_reg_idx", 64'($sampled(id_ex_out.dest_reg_idx)),
                  64'($sampled(exp_dest)));
      $error("destination index wrong");
    end

  a_alu: assert property (@(posedge clock) disable iff (rst)
                          exp_is_op |-> id_ex_out.alu_func == exp_alu)
    else begin
      log_failure("id_ex_out.alu_func", 64'($sampled(id_ex_out.alu_func)),
                  64'($sampled(exp_alu)));
      $error("operate decode wrong");
    end

  a_sel: assert property (@(posedge clock) disable iff (rst)
                          exp_flags[0] |-> {id_ex_out.opa_select, id_ex_out.opb_select} ==
                                           {exp_opa, exp_opb})
    else begin
      log_failure("id_ex_out.opa_select/opb_select",
                  64'($sampled({id_ex_out.opa_select, id_ex_out.opb_select})),
                  64'($sampled({exp_opa, exp_opb})));
      $error("operand selects wrong");
    end

  a_rega: assert property (@(posedge clock) disable iff (rst)
                           fetch_qq.valid |-> id_ex_out.rega_value == rega_qq)
    else begin
      log_failure("id_ex_out.rega_value", $sampled(id_ex_out.rega_value), $sampled(rega_qq));
      $error("register A value wrong");
    end

  a_regb: assert property (@(posedge clock) disable iff (rst)
                           fetch_qq.valid |-> id_ex_out.regb_value == regb_qq)
    else begin
      log_failure("id_ex_out.regb_value", $sampled(id_ex_out.regb_value), $sampled(regb_qq));
      $error("register B value wrong");
    end

  a_npc: assert property (@(posedge clock) disable iff (rst)
                          fetch_qq.valid |-> id_ex_out.npc == fetch_qq.npc)
    else begin
      log_failure("id_ex_out.npc", $sampled(id_ex_out.npc), $sampled(fetch_qq.npc));
      $error("npc not passed through");
    end

  a_inst: assert property (@(posedge clock) disable iff (rst)
                           fetch_qq.valid |-> id_ex_out.inst == fetch_qq.inst)
    else begin
      log_failure("id_ex_out.inst", 64'($sampled(id_ex_out.inst)),
                  64'($sampled(fetch_qq.inst)));
      $error("instruction word not passed through");
    end

  a_flush: assert property (@(posedge clock) flush |=> id_ex_out == '0)
    else begin
      log_failure("id_ex_out flags after flush", 64'($sampled(got_flags)), '0);
      $error("ID/EX not cleared by flush");
    end

  a_stall: assert property (@(posedge clock) disable iff (rst)
                            stall && !flush |=> id_ex_out == out_q)
    else begin
      log_failure("id_ex_out.npc under stall", $sampled(id_ex_out.npc), $sampled(out_q.npc));
      $error("ID/EX changed under stall");
    end

endmodule

bind decode_top decode_chk chk (.*);

// ==== src/decode_top.sv ====
// decode top, IF/ID register, decode stage and ID/EX register
module decode_top (
  input  logic            clock,
  input  logic            rst,
  input  logic            stall,     // holds both registers
  input  logic            flush,     // clears both, wins over stall
  input  id_pkg::if_id_t  if_id_in,
  input  id_pkg::wb_reg_t wb_in,     // commits even under stall
  output id_pkg::id_ex_t  id_ex_out
);

  id_pkg::if_id_t if_id_q;  // fetched word, decoded this cycle
  id_pkg::id_ex_t id_pkt;   // combinational decode result

  //////////////////////////////////////////////////////////////////////
  pipe_reg #(.payload_t(id_pkg::if_id_t)) if_id_reg (
    .clock (clock),
    .rst   (rst),
    .stall (stall),
    .flush (flush),
    .d     (if_id_in),
    .q     (if_id_q)
  );

  id_stage id_stage_0 (
    .clock    (clock),
    .wb_in    (wb_in),
    .if_id_in (if_id_q),
    .id_pkt   (id_pkt)
  );

  pipe_reg #(.payload_t(id_pkg::id_ex_t)) id_ex_reg (
    .clock (clock),
    .rst   (rst),
    .stall (stall),
    .flush (flush),
    .d     (id_pkt),
    .q     (id_ex_out)  // two edges after input
  );

endmodule

// ==== src/id_stage.sv ====
// decode stage, register file and decoder merged into the ID/EX packet
module id_stage (
  input  logic             clock,
  input  id_pkg::wb_reg_t  wb_in,
  input  id_pkg::if_id_t   if_id_in,
  output id_pkg::id_ex_t   id_pkt
);

  id_pkg::dec_out_t dec;
  logic [4:0]       ra_idx;
  logic [4:0]       rb_idx;

  // source indices sit at the same bits in every format
  assign ra_idx = if_id_in.inst.op.rega_idx;
  assign rb_idx = if_id_in.inst.op.regb_idx;

  regfile regf_0 (
    .clock   (clock),
    .rda_idx (ra_idx),
    .rdb_idx (rb_idx),
    .rda_out (id_pkt.rega_value),
    .rdb_out (id_pkt.regb_value),
    .wr_en   (wb_in.wr_en),
    .wr_idx  (wb_in.wr_idx),
    .wr_data (wb_in.wr_data)
  );

  decoder decoder_0 (
    .if_id_in (if_id_in),
    .dec_out  (dec)
  );

  // passthrough from fetch
  assign id_pkt.npc  = if_id_in.npc;
  assign id_pkt.inst = if_id_in.inst;

  // control from the decoder
  assign id_pkt.opa_select    = dec.opa_select;
  assign id_pkt.opb_select    = dec.opb_select;
  assign id_pkt.alu_func      = dec.alu_func;
  assign id_pkt.dest_reg_idx  = dec.dest_reg_idx;
  assign id_pkt.rd_mem        = dec.rd_mem;
  assign id_pkt.wr_mem        = dec.wr_mem;
  assign id_pkt.ldl_mem       = dec.ldl_mem;
  assign id_pkt.stc_mem       = dec.stc_mem;
  assign id_pkt.cond_branch   = dec.cond_branch;
  assign id_pkt.uncond_branch = dec.uncond_branch;
  assign id_pkt.halt          = dec.halt;
  assign id_pkt.cpuid         = dec.cpuid;
  assign id_pkt.illegal       = dec.illegal;
  assign id_pkt.valid         = dec.valid;

endmodule

// ==== src/pipe_reg.sv ====
// pipeline register with type-parameterized payload, hold on stall, clear on flush or reset
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     rst,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // flush beats stall, a squashed slot must not be held
  always_ff @(posedge clock) begin
    if (rst || flush) begin
      q <= '0;  // all-zero payload is a bubble
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// ==== src/decoder.sv ====
// instruction decoder, word to operand selects, ALU function, memory/branch flags, dest, illegal
`include "id_macros.svh"

module decoder (
  input  id_pkg::if_id_t   if_id_in,
  output id_pkg::dec_out_t dec_out
);

  id_pkg::inst_t inst;
  assign inst = if_id_in.inst;

  always_comb begin
    // defaults describe a bubble: no side effects, no dest
    dec_out              = '0;
    dec_out.opa_select   = id_pkg::OPA_REGA;
    dec_out.opb_select   = id_pkg::OPB_REGB;
    dec_out.alu_func     = id_pkg::ALU_ADDQ;
    dec_out.dest_reg_idx = `ID_ZERO_REG;

    if (if_id_in.valid) begin  // bubbles decode as nothing
      case (inst.op.opcode)
        `ID_OP_INTOP: begin
          dec_out.opb_select   = inst.op.lit_sel ? id_pkg::OPB_LIT : id_pkg::OPB_REGB;
          dec_out.dest_reg_idx = inst.op.regc_idx;
          case (inst.op.func)
            `ID_FN_ADD:   dec_out.alu_func = id_pkg::ALU_ADDQ;
            `ID_FN_SUB:   dec_out.alu_func = id_pkg::ALU_SUBQ;
            `ID_FN_AND:   dec_out.alu_func = id_pkg::ALU_AND;
            `ID_FN_BIS:   dec_out.alu_func = id_pkg::ALU_BIS;
            `ID_FN_XOR:   dec_out.alu_func = id_pkg::ALU_XOR;
            `ID_FN_SLL:   dec_out.alu_func = id_pkg::ALU_SLL;
            `ID_FN_SRL:   dec_out.alu_func = id_pkg::ALU_SRL;
            `ID_FN_CMPEQ: dec_out.alu_func = id_pkg::ALU_CMPEQ;
            default: begin
              dec_out.illegal      = 1'b1;
              dec_out.dest_reg_idx = `ID_ZERO_REG;  // no write from junk
            end
          endcase
        end

        //////////////////////////////////////////////////////////////////////
        // memory: address = rb + disp
        `ID_OP_LDQ, `ID_OP_LDQ_L: begin
          dec_out.opa_select   = id_pkg::OPA_REGB;
          dec_out.opb_select   = id_pkg::OPB_MEM_DISP;
          dec_out.dest_reg_idx = inst.mem.rega_idx;
          dec_out.rd_mem       = 1'b1;
          dec_out.ldl_mem      = (inst.mem.opcode == `ID_OP_LDQ_L);  // sets lock flag
        end
        `ID_OP_STQ: begin
          dec_out.opa_select = id_pkg::OPA_REGB;
          dec_out.opb_select = id_pkg::OPB_MEM_DISP;
          dec_out.wr_mem     = 1'b1;  // ra is store data, dest stays r31
        end
        `ID_OP_STQ_C: begin
          dec_out.opa_select   = id_pkg::OPA_REGB;
          dec_out.opb_select   = id_pkg::OPB_MEM_DISP;
          dec_out.dest_reg_idx = inst.mem.rega_idx;  // success flag written back
          dec_out.wr_mem       = 1'b1;
          dec_out.stc_mem      = 1'b1;
        end

        //////////////////////////////////////////////////////////////////////
        // branches: target = npc + disp
        `ID_OP_BR: begin
          dec_out.opa_select    = id_pkg::OPA_NPC;
          dec_out.opb_select    = id_pkg::OPB_BR_DISP;
          dec_out.dest_reg_idx  = inst.br.rega_idx;  // link register
          dec_out.uncond_branch = 1'b1;
        end
        `ID_OP_BCOND: begin
          dec_out.opa_select  = id_pkg::OPA_NPC;
          dec_out.opb_select  = id_pkg::OPB_BR_DISP;
          dec_out.cond_branch = 1'b1;  // ra tested in execute
        end

        `ID_OP_PAL: begin
          case (inst.pal.func)
            `ID_PAL_HALT:  dec_out.halt    = 1'b1;
            `ID_PAL_CPUID: dec_out.cpuid   = 1'b1;
            default:       dec_out.illegal = 1'b1;
          endcase
        end

        default: dec_out.illegal = 1'b1;  // unsupported opcode
      endcase
    end

    dec_out.valid = if_id_in.valid & ~dec_out.illegal;
  end

endmodule

// ==== src/regfile.sv ====
// register file, 32 x 64 bits, two read ports, one write port with forwarding, zero register
`include "id_macros.svh"

module regfile (
  input  logic                  clock,
  input  logic [`ID_RIDX_W-1:0] rda_idx,
  input  logic [`ID_RIDX_W-1:0] rdb_idx,
  output logic [`ID_XLEN-1:0]   rda_out,
  output logic [`ID_XLEN-1:0]   rdb_out,
  input  logic                  wr_en,
  input  logic [`ID_RIDX_W-1:0] wr_idx,
  input  logic [`ID_XLEN-1:0]   wr_data
);

  logic [`ID_XLEN-1:0] regs [`ID_NREGS];  // storage, contents unknown until written

  // one read port: zero reg, then same-cycle writeback, then storage
  function automatic logic [`ID_XLEN-1:0] rd_port(input logic [`ID_RIDX_W-1:0] idx);
    if (idx == `ID_ZERO_REG)
      return '0;
    else if (wr_en && (wr_idx == idx))
      return wr_data;  // bypass the write landing this edge
    else
      return regs[idx];
  endfunction

  assign rda_out = rd_port(rda_idx);
  assign rdb_out = rd_port(rdb_idx);

  // write port, r31 never stored
  always_ff @(posedge clock) begin
    if (wr_en && (wr_idx != `ID_ZERO_REG)) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

// ==== src/id_pkg.sv ====
// instruction formats, ALU and operand select enums, writeback, IF/ID, decoder and ID/EX packets
`include "id_macros.svh"

package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // instruction formats, all 32 bits wide
  typedef struct packed {
    logic [`ID_OP_W-1:0]   opcode;
    logic [`ID_RIDX_W-1:0] rega_idx;   // load dest / store data
    logic [`ID_RIDX_W-1:0] regb_idx;   // address base
    logic [15:0]           mem_disp;
  } mem_fmt_t;

  typedef struct packed {
    logic [`ID_OP_W-1:0]   opcode;
    logic [`ID_RIDX_W-1:0] rega_idx;   // link reg or tested reg
    logic [20:0]           branch_disp;
  } br_fmt_t;

  typedef struct packed {
    logic [`ID_OP_W-1:0]   opcode;
    logic [`ID_RIDX_W-1:0] rega_idx;
    logic [`ID_RIDX_W-1:0] regb_idx;
    logic [2:0]            sbz;        // should be zero
    logic                  lit_sel;    // 0 here
    logic [`ID_FN_W-1:0]   func;
    logic [`ID_RIDX_W-1:0] regc_idx;
  } op_fmt_t;

  typedef struct packed {
    logic [`ID_OP_W-1:0]   opcode;
    logic [`ID_RIDX_W-1:0] rega_idx;
    logic [7:0]            lit;        // zero-extended immediate
    logic                  lit_sel;    // 1 here
    logic [`ID_FN_W-1:0]   func;
    logic [`ID_RIDX_W-1:0] regc_idx;
  } lit_fmt_t;

  typedef struct packed {
    logic [`ID_OP_W-1:0]  opcode;
    logic [`ID_PAL_W-1:0] func;
  } pal_fmt_t;

  typedef union packed {
    mem_fmt_t mem;
    br_fmt_t  br;
    op_fmt_t  op;
    lit_fmt_t lit;
    pal_fmt_t pal;
  } inst_t;

  //////////////////////////////////////////////////////////////////////
  // control encodings
  typedef enum logic [4:0] {
    ALU_ADDQ  = 5'h00,
    ALU_SUBQ  = 5'h01,
    ALU_AND   = 5'h02,
    ALU_BIS   = 5'h03,
    ALU_XOR   = 5'h04,
    ALU_SLL   = 5'h05,
    ALU_SRL   = 5'h06,
    ALU_CMPEQ = 5'h07
  } alu_func_e;

  typedef enum logic [1:0] {
    OPA_REGA = 2'h0,  // operate
    OPA_REGB = 2'h1,  // memory address base
    OPA_NPC  = 2'h2   // branch target base
  } opa_sel_e;

  typedef enum logic [2:0] {
    OPB_REGB     = 3'h0,
    OPB_LIT      = 3'h1,
    OPB_MEM_DISP = 3'h2,
    OPB_BR_DISP  = 3'h3
  } opb_sel_e;

  //////////////////////////////////////////////////////////////////////
  // packets between stages
  typedef struct packed {
    logic                  wr_en;
    logic [`ID_RIDX_W-1:0] wr_idx;
    logic [`ID_XLEN-1:0]   wr_data;
  } wb_reg_t;

  typedef struct packed {
    logic                valid;
    logic [`ID_XLEN-1:0] npc;   // pc + 4
    inst_t               inst;
  } if_id_t;

  typedef struct packed {
    opa_sel_e              opa_select;
    opb_sel_e              opb_select;
    alu_func_e             alu_func;
    logic [`ID_RIDX_W-1:0] dest_reg_idx;  // 31 means no write
    logic                  rd_mem;
    logic                  wr_mem;
    logic                  ldl_mem;
    logic                  stc_mem;
    logic                  cond_branch;
    logic                  uncond_branch;
    logic                  halt;
    logic                  cpuid;
    logic                  illegal;
    logic                  valid;
  } dec_out_t;

  typedef struct packed {
    logic [`ID_XLEN-1:0]   npc;
    inst_t                 inst;
    logic [`ID_XLEN-1:0]   rega_value;
    logic [`ID_XLEN-1:0]   regb_value;
    opa_sel_e              opa_select;
    opb_sel_e              opb_select;
    alu_func_e             alu_func;
    logic [`ID_RIDX_W-1:0] dest_reg_idx;
    logic                  rd_mem;
    logic                  wr_mem;
    logic                  ldl_mem;
    logic                  stc_mem;
    logic                  cond_branch;
    logic                  uncond_branch;
    logic                  halt;
    logic                  cpuid;
    logic                  illegal;
    logic                  valid;
  } id_ex_t;

endpackage

// ==== src/id_macros.svh ====
// word and register widths, opcode, function and PAL codes for the decode stage
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// data path and register file geometry
`define ID_XLEN      64
`define ID_NREGS     32
`define ID_RIDX_W    5      // bits in a register index
`define ID_ZERO_REG  5'd31  // always reads zero, writes dropped

//////////////////////////////////////////////////////////////////////
// opcodes, bits [31:26] of the instruction word
`define ID_OP_W      6
`define ID_OP_INTOP  6'h10  // integer operate, reg or literal form
`define ID_OP_LDQ    6'h29
`define ID_OP_STQ    6'h2d
`define ID_OP_LDQ_L  6'h2b  // load-locked
`define ID_OP_STQ_C  6'h2f  // store-conditional
`define ID_OP_BR     6'h30  // unconditional, writes link reg
`define ID_OP_BCOND  6'h39  // conditional branch on ra
`define ID_OP_PAL    6'h00  // call_pal

//////////////////////////////////////////////////////////////////////
// integer operate function codes, bits [11:5]
`define ID_FN_W      7
`define ID_FN_ADD    7'h20
`define ID_FN_SUB    7'h29
`define ID_FN_AND    7'h00
`define ID_FN_BIS    7'h24
`define ID_FN_XOR    7'h40
`define ID_FN_SLL    7'h39
`define ID_FN_SRL    7'h34
`define ID_FN_CMPEQ  7'h2d

// PAL function codes, bits [25:0]
`define ID_PAL_W     26
`define ID_PAL_HALT  26'h0000555
`define ID_PAL_CPUID 26'h000009f

`endif
